// File: Makefile
# Verilator build and run for the SPI write harness testbench

TOP := tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" sim.log || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: design/chip_pkg.sv
// Shared types and constants for the SPI write harness.
// Holds the RAM write request, the watched-word views and the status codes
// that the monitor and the testbench compare against.

package chip_pkg;

  // One write frame is an address byte followed by four data bytes
  parameter int unsigned FRAME_BYTES = 5;

  // Software test status codes
  parameter logic [15:0] STATUS_IN_TEST = 16'h4354;
  parameter logic [15:0] STATUS_PASSED  = 16'h900d;
  parameter logic [15:0] STATUS_FAILED  = 16'hbaad;

  // Word write request carried over the req/ack handshake
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } ram_req_t;

  // Status word layout, code in the low half
  typedef struct packed {
    logic [15:0] rsvd;
    logic [15:0] code;
  } status_view_t;

  // Log word layout, one character in the low byte
  typedef struct packed {
    logic [23:0] rsvd;
    logic [7:0]  char_val;
  } log_view_t;

  // Same write data seen as status, as log character or as a raw word
  typedef union packed {
    status_view_t status;
    log_view_t    log;
    logic [31:0]  raw;
  } sw_word_u;

endpackage

// File: design/chip_top.sv
// Top of the SPI write harness.
// A host writes RAM words over SPI; the status and log addresses are
// watched for test results and an idle timer catches hung tests.

`timescale 1ns/1ps

module chip_top #(
  parameter logic [7:0]  STATUS_ADDR = 8'hf0,
  parameter logic [7:0]  LOG_ADDR    = 8'hf4,
  parameter int unsigned IDLE_LIMIT  = 2000,
  parameter int unsigned RAM_WORDS   = 256
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        spi_sck_i,
  input  logic        spi_csb_i,
  input  logic        spi_sdi_i,
  input  logic [7:0]  rd_addr_i,
  output logic [31:0] rd_data_o,
  output logic        test_done_o,
  output logic        test_pass_o,
  output logic        log_valid_o,
  output logic [7:0]  log_char_o,
  output logic        hang_o,
  output logic        overrun_o
);

  logic               frame_valid;
  chip_pkg::ram_req_t frame;
  logic               req;
  logic               ack;
  chip_pkg::ram_req_t ram_req;
  logic               write_seen;

  spi_frame_rx u_spi_frame_rx (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .spi_sck_i     (spi_sck_i),
    .spi_csb_i     (spi_csb_i),
    .spi_sdi_i     (spi_sdi_i),
    .frame_valid_o (frame_valid),
    .frame_o       (frame)
  );

  write_ctrl_fsm u_write_ctrl_fsm (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .frame_valid_i (frame_valid),
    .frame_i       (frame),
    .req_o         (req),
    .ram_req_o     (ram_req),
    .ack_i         (ack),
    .overrun_o     (overrun_o)
  );

  sim_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_sim_ram (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req),
    .ram_req_i (ram_req),
    .ack_o     (ack),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

  // Monitor taps the same handshake the RAM sees
  sw_status_mon #(
    .STATUS_ADDR (STATUS_ADDR),
    .LOG_ADDR    (LOG_ADDR)
  ) u_sw_status_mon (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req),
    .ack_i        (ack),
    .ram_req_i    (ram_req),
    .write_seen_o (write_seen),
    .test_done_o  (test_done_o),
    .test_pass_o  (test_pass_o),
    .log_valid_o  (log_valid_o),
    .log_char_o   (log_char_o)
  );

  // Timer stops once the test has reported a result
  idle_timer #(
    .IDLE_LIMIT (IDLE_LIMIT)
  ) u_idle_timer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .run_i    (!test_done_o),
    .clear_i  (write_seen),
    .hang_o   (hang_o)
  );

endmodule

// File: design/idle_timer.sv
// Watchdog for a stalled test.
// Counts cycles without a completed write and raises a sticky hang flag
// once the count reaches IDLE_LIMIT.

`timescale 1ns/1ps

module idle_timer #(
  parameter int unsigned IDLE_LIMIT = 2000
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic run_i,
  input  logic clear_i,
  output logic hang_o
);

  localparam int unsigned CntW = $clog2(IDLE_LIMIT + 1);

  logic [CntW-1:0] cnt_q;
  logic            hang_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      hang_q <= 1'b0;
    end else begin
      if (clear_i) begin
        cnt_q <= '0;
      end else if (run_i && cnt_q != CntW'(IDLE_LIMIT)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Saturated count means no write for the whole window
      if (cnt_q == CntW'(IDLE_LIMIT)) begin
        hang_q <= 1'b1;
      end
    end
  end

  assign hang_o = hang_q;

endmodule

// File: design/sim_ram.sv
// Simulation word memory with a req/ack write port.
// Writes on the clock that raises ack, returns ack low after req falls,
// and serves a separate registered read port.

`timescale 1ns/1ps

module sim_ram #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  chip_pkg::ram_req_t ram_req_i,
  output logic               ack_o,
  input  logic [7:0]         rd_addr_i,
  output logic [31:0]        rd_data_o
);

  localparam int unsigned AddrW = $clog2(RAM_WORDS);

  logic [31:0] mem_q [RAM_WORDS];
  logic        ack_q;
  logic        wr_en;
  logic [31:0] rd_data_q;

  // New request seen, ack not yet raised
  assign wr_en = req_i && !ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else if (wr_en) begin
      ack_q <= 1'b1;
    end else if (!req_i) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[ram_req_i.addr[AddrW-1:0]] <= ram_req_i.data;
    end
    rd_data_q <= mem_q[rd_addr_i[AddrW-1:0]];
  end

  assign ack_o     = ack_q;
  assign rd_data_o = rd_data_q;

  // Master has to wait for ack to fall before starting the next write
  no_early_req_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $rose(req_i) |-> !ack_o
  );

endmodule

// File: design/spi_frame_rx.sv
// SPI mode 0 frame receiver, MSB first.
// Synchronizes the pins to clk_i and assembles five-byte write frames.
// A frame is passed on only when csb rises after whole bytes.

`timescale 1ns/1ps

module spi_frame_rx (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               spi_sck_i,
  input  logic               spi_csb_i,
  input  logic               spi_sdi_i,
  output logic               frame_valid_o,
  output chip_pkg::ram_req_t frame_o
);

  localparam int unsigned FrameW = $bits(chip_pkg::ram_req_t);

  logic [1:0]        sck_sync;
  logic [1:0]        csb_sync;
  logic [1:0]        sdi_sync;
  logic              sck_q;
  logic              csb_q;
  logic              sck_rise;
  logic              csb_rise;
  logic [2:0]        bit_cnt;
  logic [2:0]        byte_cnt;
  logic [FrameW-1:0] shift_q;
  logic              frame_valid_q;

  // Two-flop synchronizers plus one stage for edge detection
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_sync <= 2'b00;
      csb_sync <= 2'b11;
      sdi_sync <= 2'b00;
      sck_q    <= 1'b0;
      csb_q    <= 1'b1;
    end else begin
      sck_sync <= {sck_sync[0], spi_sck_i};
      csb_sync <= {csb_sync[0], spi_csb_i};
      sdi_sync <= {sdi_sync[0], spi_sdi_i};
      sck_q    <= sck_sync[1];
      csb_q    <= csb_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_q;
  assign csb_rise = csb_sync[1] & ~csb_q;

  // Bit and byte counters, cleared while deselected
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt  <= 3'd0;
      byte_cnt <= 3'd0;
    end else if (csb_sync[1]) begin
      bit_cnt  <= 3'd0;
      byte_cnt <= 3'd0;
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 3'd1;
      // Saturate so long frames never wrap back to a valid count
      if (bit_cnt == 3'd7 && byte_cnt != 3'd7) begin
        byte_cnt <= byte_cnt + 3'd1;
      end
    end
  end

  // Address lands in the top byte once all five bytes are in
  always_ff @(posedge clk_i) begin
    if (!csb_sync[1] && sck_rise) begin
      shift_q <= {shift_q[FrameW-2:0], sdi_sync[1]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_valid_q <= 1'b0;
    end else begin
      frame_valid_q <= csb_rise && (bit_cnt == 3'd0) &&
                       (byte_cnt == 3'(chip_pkg::FRAME_BYTES));
    end
  end

  assign frame_valid_o = frame_valid_q;
  assign frame_o       = chip_pkg::ram_req_t'(shift_q);

endmodule

// File: design/sw_status_mon.sv
// Monitor for software status and log writes to the RAM.
// Picks out completed writes at two fixed word addresses and turns them
// into sticky test results and a one-cycle log character strobe.

`timescale 1ns/1ps

module sw_status_mon #(
  parameter logic [7:0] STATUS_ADDR = 8'hf0,
  parameter logic [7:0] LOG_ADDR    = 8'hf4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic               ack_i,
  input  chip_pkg::ram_req_t ram_req_i,
  output logic               write_seen_o,
  output logic               test_done_o,
  output logic               test_pass_o,
  output logic               log_valid_o,
  output logic [7:0]         log_char_o
);

  logic              ack_q;
  logic              write_done;
  chip_pkg::sw_word_u word;
  logic              done_q;
  logic              pass_q;
  logic              log_valid_q;
  logic [7:0]        log_char_q;

  // First cycle of ack while the request is still up
  assign write_done = req_i && ack_i && !ack_q;
  assign word       = chip_pkg::sw_word_u'(ram_req_i.data);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      done_q      <= 1'b0;
      pass_q      <= 1'b0;
      log_valid_q <= 1'b0;
    end else begin
      ack_q       <= ack_i;
      log_valid_q <= write_done && (ram_req_i.addr == LOG_ADDR);
      // First final verdict wins
      if (write_done && ram_req_i.addr == STATUS_ADDR && !done_q) begin
        case (word.status.code)
          chip_pkg::STATUS_PASSED: begin
            done_q <= 1'b1;
            pass_q <= 1'b1;
          end
          chip_pkg::STATUS_FAILED: begin
            done_q <= 1'b1;
            pass_q <= 1'b0;
          end
          chip_pkg::STATUS_IN_TEST: ;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_done && ram_req_i.addr == LOG_ADDR) begin
      log_char_q <= word.log.char_val;
    end
  end

  assign write_seen_o = write_done;
  assign test_done_o  = done_q;
  assign test_pass_o  = pass_q;
  assign log_valid_o  = log_valid_q;
  assign log_char_o   = log_char_q;

  // A pass verdict only exists as part of a finished test
  pass_needs_done_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    test_pass_o |-> test_done_o
  );

endmodule

// File: design/write_ctrl_fsm.sv
// Write controller between the SPI receiver and the simulation RAM.
// Runs one four-phase req/ack handshake per accepted frame and flags
// frames that arrive while a handshake is still in flight.

`timescale 1ns/1ps

module write_ctrl_fsm (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               frame_valid_i,
  input  chip_pkg::ram_req_t frame_i,
  output logic               req_o,
  output chip_pkg::ram_req_t ram_req_o,
  input  logic               ack_i,
  output logic               overrun_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    REQ     = 2'd1,
    RELEASE = 2'd2
  } state_e;

  state_e             state_q;
  state_e             state_d;
  chip_pkg::ram_req_t frame_q;
  logic               overrun_q;
  logic               accept;

  assign accept = frame_valid_i && (state_q == IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (frame_valid_i) begin
          state_d = REQ;
        end
      end
      // Drop req on the clock after ack is seen
      REQ: begin
        if (ack_i) begin
          state_d = RELEASE;
        end
      end
      // Wait for the RAM to return ack low
      RELEASE: begin
        if (!ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      overrun_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (frame_valid_i && state_q != IDLE) begin
        overrun_q <= 1'b1;
      end
    end
  end

  // Request held from acceptance until the next accepted frame
  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame_q <= frame_i;
    end
  end

  assign req_o     = (state_q == REQ);
  assign ram_req_o = frame_q;
  assign overrun_o = overrun_q;

  // Request payload must not move until the RAM has acknowledged it
  req_stable_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (req_o && !ack_i) |=> $stable(ram_req_o)
  );

endmodule

// File: files.f
+incdir+testbench
design/chip_pkg.sv
design/spi_frame_rx.sv
design/write_ctrl_fsm.sv
design/sim_ram.sv
design/sw_status_mon.sv
design/idle_timer.sv
design/chip_top.sv
testbench/tb.sv

// File: testbench/tb_spi_tasks.svh
// SPI mode 0 bit-banging tasks and the RAM read task.
// Included inside module tb and drives its signals on the rising clock edge.

// Data set while sck is low, sampled by the DUT on the rising edge
task automatic spi_send_bit(input logic bit_val);
  @(posedge clk);
  spi_sdi <= bit_val;
  repeat (SpiHalf) @(posedge clk);
  spi_sck <= 1'b1;
  repeat (SpiHalf) @(posedge clk);
  spi_sck <= 1'b0;
endtask

// MSB first
task automatic spi_send_byte(input logic [7:0] byte_val);
  int i;
  for (i = 7; i >= 0; i--) begin
    spi_send_bit(byte_val[i]);
  end
endtask

task automatic spi_select();
  @(posedge clk);
  spi_csb <= 1'b0;
  repeat (SpiHalf) @(posedge clk);
endtask

// Gap after csb rises covers the frame pulse and one RAM handshake
task automatic spi_deselect();
  repeat (SpiHalf) @(posedge clk);
  spi_csb <= 1'b1;
  repeat (FrameGap) @(posedge clk);
endtask

// Address byte first, then the data word MSB first
task automatic spi_write_word(input logic [7:0] addr, input logic [31:0] data);
  logic [8*chip_pkg::FRAME_BYTES-1:0] bits;
  int                                 i;
  bits = {addr, data};
  spi_select();
  for (i = 0; i < chip_pkg::FRAME_BYTES; i++) begin
    spi_send_byte(bits[8*(chip_pkg::FRAME_BYTES-1-i) +: 8]);
  end
  spi_deselect();
endtask

// Read data shows up one clock after the address is applied
task automatic ram_read(input logic [7:0] addr, output logic [31:0] data);
  @(posedge clk);
  rd_addr <= addr;
  @(posedge clk);
  @(negedge clk);
  data = rd_data;
endtask

// File: testbench/tb.sv
// Directed testbench for the SPI write harness.
// Writes words over SPI, then checks the read port, the log strobe,
// the status results, frame dropping and the hang flag.

`timescale 1ns/1ps

module tb;

  localparam logic [7:0] StatusAddr = 8'hf0;
  localparam logic [7:0] LogAddr    = 8'hf4;
  localparam int         IdleLimit  = 2000;
  localparam int         SpiHalf    = 4;
  localparam int         FrameGap   = 12;

  logic        clk;
  logic        arst_n;
  logic        spi_sck;
  logic        spi_csb;
  logic        spi_sdi;
  logic [7:0]  rd_addr;
  logic [31:0] rd_data;
  logic        test_done;
  logic        test_pass;
  logic        log_valid;
  logic [7:0]  log_char;
  logic        hang;
  logic        overrun;
  integer      seed = 32'h6d739cda;
  int          value_errors = 0;
  int          timeouts = 0;
  logic [7:0]  log_q [$];

  chip_top #(
    .STATUS_ADDR (StatusAddr),
    .LOG_ADDR    (LogAddr),
    .IDLE_LIMIT  (IdleLimit),
    .RAM_WORDS   (256)
  ) u_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .spi_sck_i   (spi_sck),
    .spi_csb_i   (spi_csb),
    .spi_sdi_i   (spi_sdi),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .test_done_o (test_done),
    .test_pass_o (test_pass),
    .log_valid_o (log_valid),
    .log_char_o  (log_char),
    .hang_o      (hang),
    .overrun_o   (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every log strobe lands here, in order
  always @(negedge clk) begin
    if (log_valid) begin
      log_q.push_back(log_char);
    end
  end

  `include "tb_spi_tasks.svh"

  task automatic mismatch(input string msg);
    value_errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("Gave up at %0t waiting for %s", $time, what);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic poll_word(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    int          n;
    got = '0;
    for (n = 0; n < 10; n++) begin
      ram_read(addr, got);
      if (got === exp) begin
        break;
      end
    end
    if (got !== exp) begin
      mismatch($sformatf("word at %02h reads %08h, expected %08h", addr, got, exp));
    end
  endtask

  task automatic wait_done();
    int n;
    for (n = 0; n < 40; n++) begin
      @(negedge clk);
      if (test_done) begin
        break;
      end
    end
    if (!test_done) begin
      timed_out("test_done_o");
    end
  endtask

  task automatic expect_log_char(input logic [7:0] exp);
    logic [7:0] got;
    int         n;
    for (n = 0; n < 40; n++) begin
      @(negedge clk);
      if (log_q.size() != 0) begin
        break;
      end
    end
    if (log_q.size() == 0) begin
      timed_out("log_valid_o");
    end else begin
      got = log_q.pop_front();
      if (got !== exp) begin
        mismatch($sformatf("log char %02h, expected %02h", got, exp));
      end
    end
  endtask

  task automatic write_read_back();
    logic [31:0] r;
    logic [7:0]  addr;
    logic [31:0] data;
    int          i;
    for (i = 0; i < 8; i++) begin
      r    = $random(seed);
      addr = 8'(r % 32'd240);
      data = $random(seed);
      spi_write_word(addr, data);
      poll_word(addr, data);
    end
  endtask

  task automatic log_capture();
    string text;
    int    i;
    text = "hi ok";
    for (i = 0; i < text.len(); i++) begin
      spi_write_word(LogAddr, {24'h0, text[i]});
      expect_log_char(text[i]);
    end
    if (log_q.size() != 0) begin
      mismatch($sformatf("%0d extra log strobes", log_q.size()));
    end
    if (test_done) begin
      mismatch("test_done_o set by log writes");
    end
  endtask

  task automatic status_decode();
    spi_write_word(StatusAddr, {16'h0, chip_pkg::STATUS_IN_TEST});
    poll_word(StatusAddr, {16'h0, chip_pkg::STATUS_IN_TEST});
    if (test_done) begin
      mismatch("test_done_o set by in-test status");
    end
    spi_write_word(StatusAddr, {16'h0, chip_pkg::STATUS_FAILED});
    wait_done();
    if (!test_done || test_pass) begin
      mismatch($sformatf("done %b pass %b after failed status, expected 1 0",
                         test_done, test_pass));
    end
    apply_reset();
    @(negedge clk);
    if (test_done || test_pass) begin
      mismatch("status results not cleared by reset");
    end
    spi_write_word(StatusAddr, {16'h0, chip_pkg::STATUS_PASSED});
    wait_done();
    if (!test_done || !test_pass) begin
      mismatch($sformatf("done %b pass %b after passed status, expected 1 1",
                         test_done, test_pass));
    end
  endtask

  task automatic bad_frame_drop();
    logic [31:0] keep;
    logic [40:0] bits;
    int          i;
    keep = $random(seed);
    // Low byte is what a four-byte frame leaves in the address field
    keep[7:0] = 8'h20;
    bits = {1'b1, 8'h20, ~keep};
    spi_write_word(8'h20, keep);
    poll_word(8'h20, keep);
    // Four whole bytes only
    spi_select();
    for (i = 0; i < 4; i++) begin
      spi_send_byte(bits[8*(3-i) +: 8]);
    end
    spi_deselect();
    // Five bytes plus one stray bit, last 40 bits shaped as a write to 8'h20
    spi_select();
    for (i = 0; i < 5; i++) begin
      spi_send_byte(bits[8*(4-i)+1 +: 8]);
    end
    spi_send_bit(bits[0]);
    spi_deselect();
    poll_word(8'h20, keep);
    if (overrun) begin
      mismatch("overrun_o set by dropped frames");
    end
  endtask

  task automatic hang_detect();
    int n;
    apply_reset();
    for (n = 0; n < IdleLimit + 100; n++) begin
      @(negedge clk);
      if (hang) begin
        break;
      end
    end
    if (!hang) begin
      timed_out("hang_o");
    end else if (n < IdleLimit) begin
      mismatch($sformatf("hang_o rose after %0d cycles, limit %0d", n, IdleLimit));
    end
    apply_reset();
    // Idle first so only the write's clear keeps the count below the limit
    repeat (IdleLimit / 2) @(posedge clk);
    spi_write_word(8'h10, $random(seed));
    repeat (IdleLimit / 2) @(posedge clk);
    @(negedge clk);
    if (hang) begin
      mismatch("hang_o set half a limit after a write");
    end
  endtask

  initial begin
    arst_n  = 1'b0;
    spi_sck = 1'b0;
    spi_csb = 1'b1;
    spi_sdi = 1'b0;
    rd_addr = 8'h00;
    apply_reset();
    write_read_back();
    log_capture();
    status_decode();
    bad_frame_drop();
    hang_detect();
    $display("Value errors: %0d, timeouts: %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
